//--- src.f
isaPkg.sv
pipePkg.sv
instDecoder.sv
aluUnit.sv
issueLane.sv
pairIssue.sv
regFile.sv
dualIssueCore.sv
dualIssueCore_properties.sv
dualIssueCore_tb.sv

//--- dualIssueCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dualIssueCore_tb
    import isaPkg::*, pipePkg::*;
();

    localparam int AcceptTimeout = 20;
    localparam int DrainTimeout  = 50;

    logic    clk = 1'b0;
    logic    rstN;
    logic    instValid;
    instT    inst1, inst2;
    logic    fetchStall, wbMasterEn, wbSlaveEn;
    regAddrT wbMasterReg, wbSlaveReg;
    wordT    wbMasterData, wbSlaveData;

    wordT    modelRegs [NumRegs];  // in-order architectural state
    regAddrT expRegQ [$];
    wordT    expDataQ [$];
    integer  seed = 56615;

    functE   rFns [10] = '{FnSll, FnSrl, FnAddu, FnSubu, FnAnd,
                           FnOr, FnXor, FnNor, FnSlt, FnSltu};
    opcodeE  iOps [6]  = '{OpAddiu, OpSlti, OpAndi, OpOri, OpXori, OpLui};

    always #10 clk = ~clk;

    dualIssueCore dut (
        .clk(clk), .rstN_i(rstN), .inst1_i(inst1), .inst2_i(inst2),
        .instValid_i(instValid), .fetchStall_o(fetchStall),
        .wbMasterEn_o(wbMasterEn), .wbMasterReg_o(wbMasterReg), .wbMasterData_o(wbMasterData),
        .wbSlaveEn_o(wbSlaveEn), .wbSlaveReg_o(wbSlaveReg), .wbSlaveData_o(wbSlaveData)
    );

    task automatic failTest(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkReg(input string name, input regAddrT exp, input regAddrT act);
        if (act !== exp) begin
            failTest($sformatf("Error at %0t: %s expected %0d got %0d", $time, name, exp, act));
        end
    endtask

    task automatic checkData(input string name, input wordT exp, input wordT act);
        if (act !== exp) begin
            failTest($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, act));
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        if (act != exp) begin
            failTest($sformatf("Error at %0t: %s expected %0d got %0d", $time, name, exp, act));
        end
    endtask

    function automatic instT rType(functE fn, regAddrT rd, regAddrT rs, regAddrT rt,
                                   logic [4:0] sh);
        return {OpSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic instT iType(opcodeE op, regAddrT rt, regAddrT rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // register written by an instruction, 0 when nothing is written
    function automatic regAddrT destOf(instT inst);
        logic [5:0] op;
        logic [5:0] fn;
        op = inst[31:26];
        fn = inst[5:0];
        if (op == OpSpecial) begin
            return (fn inside {FnSll, FnSrl, FnAddu, FnSubu, FnAnd, FnOr, FnXor, FnNor,
                               FnSlt, FnSltu}) ? inst[RdLsb +: 5] : '0;
        end
        return (op inside {OpAddiu, OpSlti, OpAndi, OpOri, OpXori, OpLui}) ? inst[RtLsb +: 5] : '0;
    endfunction

    function automatic bit dependentPair(instT i1, instT i2);
        regAddrT d;
        d = destOf(i1);
        return (d != 0) && (i2[RsLsb +: 5] == d ||
                            (i2[31:26] == OpSpecial && i2[RtLsb +: 5] == d));
    endfunction

    task automatic applyModel(input instT inst);
        wordT    a, b, sext, zext, res;
        regAddrT dst;
        a    = modelRegs[inst[RsLsb +: 5]];
        b    = modelRegs[inst[RtLsb +: 5]];
        sext = {{16{inst[15]}}, inst[15:0]};
        zext = {16'h0, inst[15:0]};
        dst  = destOf(inst);
        res  = '0;
        if (inst[31:26] == OpSpecial) begin
            case (inst[5:0])
                FnSll:   res = b << inst[10:6];
                FnSrl:   res = b >> inst[10:6];
                FnAddu:  res = a + b;
                FnSubu:  res = a - b;
                FnAnd:   res = a & b;
                FnOr:    res = a | b;
                FnXor:   res = a ^ b;
                FnNor:   res = ~(a | b);
                FnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FnSltu:  res = (a < b) ? 32'd1 : 32'd0;
                default: res = '0;
            endcase
        end else begin
            case (inst[31:26])
                OpAddiu: res = a + sext;
                OpSlti:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                OpAndi:  res = a & zext;
                OpOri:   res = a | zext;
                OpXori:  res = a ^ zext;
                OpLui:   res = {inst[15:0], 16'h0};
                default: res = '0;
            endcase
        end
        if (dst != 0) begin
            modelRegs[dst] = res;
            expRegQ.push_back(dst);
            expDataQ.push_back(res);
        end
    endtask

    task automatic sendPair(input instT i1, input instT i2);
        int stalls;
        int expStalls;
        bit accepted;
        stalls    = 0;
        accepted  = 1'b0;
        expStalls = dependentPair(i1, i2) ? 1 : 0;
        applyModel(i1);  // master is older
        applyModel(i2);
        inst1     <= i1;
        inst2     <= i2;
        instValid <= 1'b1;
        for (int n = 0; n < AcceptTimeout && !accepted; n++) begin
            @(posedge clk);
            if (fetchStall) stalls++;
            else accepted = 1'b1;
        end
        if (!accepted) failTest("instruction pair was never accepted by the core");
        checkCount("fetchStall_o cycles", expStalls, stalls);
    endtask

    task automatic drain();
        int n;
        instValid <= 1'b0;
        n = 0;
        while (expRegQ.size() != 0 && n < DrainTimeout) begin
            @(posedge clk);
            n++;
        end
        if (expRegQ.size() != 0) failTest("expected writes never showed up on the wb ports");
        repeat (3) @(posedge clk);  // room for stray writes
    endtask

    task automatic takeWrite(input string lane, input regAddrT r, input wordT d);
        if (expRegQ.size() == 0) failTest({"unexpected write on the ", lane, " port"});
        checkReg({lane, "Reg_o"}, expRegQ.pop_front(), r);
        checkData({lane, "Data_o"}, expDataQ.pop_front(), d);
    endtask

    // master before slave within a cycle keeps program order
    always @(posedge clk) begin
        if (rstN) begin
            if (wbMasterEn) takeWrite("wbMaster", wbMasterReg, wbMasterData);
            if (wbSlaveEn) takeWrite("wbSlave", wbSlaveReg, wbSlaveData);
        end
    end

    always @(posedge clk) begin
        if (dut.props.failCount != 0) begin
            failTest("an assertion in the bound properties failed");
        end
    end

    task automatic testRType();
        sendPair(iType(OpAddiu, 1, 0, 16'hfffb), iType(OpAddiu, 2, 0, 16'h0007));  // r1 = -5
        sendPair(rType(FnAddu, 4, 1, 2, 0), rType(FnSubu, 5, 1, 2, 0));
        sendPair(rType(FnAnd, 6, 1, 2, 0), rType(FnOr, 7, 1, 2, 0));
        sendPair(rType(FnXor, 8, 1, 2, 0), rType(FnNor, 9, 1, 2, 0));
        sendPair(rType(FnSlt, 10, 1, 2, 0), rType(FnSltu, 11, 1, 2, 0));
        sendPair(rType(FnSll, 12, 0, 2, 5'd4), rType(FnSrl, 13, 0, 1, 5'd3));
        drain();
    endtask

    task automatic testIType();
        sendPair(iType(OpAddiu, 14, 2, 16'h8001), iType(OpSlti, 15, 2, 16'hffff));
        sendPair(iType(OpAndi, 16, 1, 16'hff00), iType(OpOri, 17, 0, 16'h8000));
        sendPair(iType(OpXori, 18, 1, 16'hffff), iType(OpLui, 19, 0, 16'habcd));
        sendPair(iType(OpSlti, 20, 1, 16'h0003), iType(OpSlti, 21, 2, 16'h0003));
        drain();
    endtask

    task automatic testForwarding();
        sendPair(iType(OpAddiu, 20, 0, 16'h0005), iType(OpAddiu, 21, 0, 16'h0009));
        sendPair(rType(FnAddu, 22, 20, 21, 0), rType(FnSubu, 23, 21, 20, 0));
        sendPair(rType(FnAddu, 24, 22, 20, 0), rType(FnOr, 25, 23, 21, 0));
        sendPair(iType(OpAddiu, 26, 0, 16'h0001), iType(OpAddiu, 26, 0, 16'h0002));
        sendPair(iType(OpAddiu, 29, 0, 16'h0003), iType(OpAddiu, 30, 0, 16'h0004));
        // r26 sits in both writeback slots here
        sendPair(rType(FnAddu, 27, 26, 29, 0), rType(FnSubu, 28, 30, 26, 0));
        sendPair(iType(OpAddiu, 26, 0, 16'h0007), iType(OpAddiu, 26, 0, 16'h0008));
        sendPair(rType(FnAddu, 31, 26, 0, 0), rType(FnXor, 1, 27, 26, 0));  // both in execute
        drain();
    endtask

    task automatic testDependent();
        sendPair(iType(OpOri, 3, 0, 16'h1234), rType(FnAddu, 4, 3, 3, 0));
        sendPair(iType(OpLui, 5, 0, 16'h8000), rType(FnSltu, 6, 0, 5, 0));  // only rt hits
        sendPair(rType(FnSubu, 7, 0, 3, 0), iType(OpAddiu, 8, 7, 16'hffff));
        drain();
    endtask

    task automatic testSameReg();
        sendPair(iType(OpAddiu, 9, 0, 16'h0011), iType(OpAddiu, 9, 0, 16'h0022));
        sendPair(rType(FnAddu, 10, 9, 0, 0), iType(OpAddiu, 0, 9, 16'h0005));
        sendPair(32'hfc0b_0000, 32'h0000_583f);  // unknown opcode and funct, both name r11
        sendPair(rType(FnOr, 0, 9, 9, 0), iType(OpOri, 0, 0, 16'h00ff));
        drain();
        sendPair(rType(FnAddu, 11, 9, 0, 0), rType(FnSll, 12, 0, 9, 5'd1));
        drain();
    endtask

    function automatic instT randomInst();
        int         pick;
        regAddrT    rd, rs, rt;
        logic [4:0] sh;
        pick = {$random(seed)} % 16;
        rd   = {$random(seed)} % 8;
        rs   = {$random(seed)} % 8;
        rt   = {$random(seed)} % 8;
        sh   = $random(seed);
        if (pick < 10) return rType(rFns[pick], rd, rs, rt, sh);
        return iType(iOps[pick - 10], rd, rs, $random(seed));
    endfunction

    task automatic testRandom();
        instT a, b;
        for (int n = 0; n < 200; n++) begin
            a = randomInst();
            b = randomInst();
            sendPair(a, b);
        end
        drain();
    endtask

    initial begin
        rstN      = 1'b0;
        instValid = 1'b0;
        inst1     = '0;
        inst2     = '0;
        for (int r = 0; r < NumRegs; r++) begin
            modelRegs[r] = '0;
        end
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        testRType();
        testIType();
        testForwarding();
        testDependent();
        testSameReg();
        testRandom();
        if (expRegQ.size() == 0 && dut.props.failCount == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            failTest("writes outstanding or an assertion failed at end of run");
        end
    end

endmodule

`default_nettype wire

//--- dualIssueCore_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dualIssueCoreProperties
    import isaPkg::*;
(
    input wire          clk,
    input wire          rstN_i,
    input wire          fetchStall_i,
    input wire          wbMasterEn_i,
    input wire regAddrT wbMasterReg_i,
    input wire          wbSlaveEn_i,
    input wire regAddrT wbSlaveReg_i
);

    int failCount = 0;  // number of assertion failures so far

    // first cycle out of reset is quiet
    resetQuiet: assert property (@(posedge clk)
        $rose(rstN_i) |-> !fetchStall_i && !wbMasterEn_i && !wbSlaveEn_i)
        else begin
            failCount++;
            $error("core active in the first cycle after reset");
        end

    resetHoldsWb: assert property (@(posedge clk)
        !rstN_i |=> !wbMasterEn_i && !wbSlaveEn_i)
        else begin
            failCount++;
            $error("wb enable high during reset");
        end

    // r0 writes are dropped in decode
    masterNotR0: assert property (@(posedge clk) disable iff (!rstN_i)
        wbMasterEn_i |-> wbMasterReg_i != '0)
        else begin
            failCount++;
            $error("master lane wrote register 0");
        end

    slaveNotR0: assert property (@(posedge clk) disable iff (!rstN_i)
        wbSlaveEn_i |-> wbSlaveReg_i != '0)
        else begin
            failCount++;
            $error("slave lane wrote register 0");
        end

    stallOneCycle: assert property (@(posedge clk) disable iff (!rstN_i)
        fetchStall_i |=> !fetchStall_i)
        else begin
            failCount++;
            $error("fetch stall held for two cycles");
        end

endmodule

bind dualIssueCore dualIssueCoreProperties props (
    .clk(clk), .rstN_i(rstN_i), .fetchStall_i(fetchStall_o),
    .wbMasterEn_i(wbMasterEn_o), .wbMasterReg_i(wbMasterReg_o),
    .wbSlaveEn_i(wbSlaveEn_o), .wbSlaveReg_i(wbSlaveReg_o)
);

`default_nettype wire

//--- dualIssueCore.sv
`timescale 1ns/1ps
`default_nettype none

module dualIssueCore
    import isaPkg::*, pipePkg::*;
(
    input  wire          clk,
    input  wire          rstN_i,
    input  wire instT    inst1_i,
    input  wire instT    inst2_i,
    input  wire          instValid_i,
    output wire          fetchStall_o,
    output wire          wbMasterEn_o,
    output wire regAddrT wbMasterReg_o,
    output wire wordT    wbMasterData_o,
    output wire          wbSlaveEn_o,
    output wire regAddrT wbSlaveReg_o,
    output wire wordT    wbSlaveData_o
);

    wire issueMaster, issueSlave;

    // execute stage of both lanes, used for forwarding
    wire regAddrT mExDest, sExDest;
    wire          mExEn, sExEn;
    wire wordT    mExRes, sExRes;

    wire regAddrT rdAddr0, rdAddr1, rdAddr2, rdAddr3;
    wire wordT    rdData0, rdData1, rdData2, rdData3;

    pairIssue issue (
        .clk(clk), .rstN_i(rstN_i), .inst1_i(inst1_i), .inst2_i(inst2_i),
        .instValid_i(instValid_i), .issueMaster_o(issueMaster),
        .issueSlave_o(issueSlave), .fetchStall_o(fetchStall_o)
    );

    issueLane #(.IsSlave(1'b0)) masterLane (
        .clk(clk), .rstN_i(rstN_i), .issue_i(issueMaster), .inst_i(inst1_i),
        .rdData1_i(rdData0), .rdData2_i(rdData1), .rdAddr1_o(rdAddr0), .rdAddr2_o(rdAddr1),
        .peerExDest_i(sExDest), .peerExEn_i(sExEn), .peerExResult_i(sExRes),
        .peerWbDest_i(wbSlaveReg_o), .peerWbEn_i(wbSlaveEn_o), .peerWbResult_i(wbSlaveData_o),
        .exDest_o(mExDest), .exEn_o(mExEn), .exResult_o(mExRes),
        .wbDest_o(wbMasterReg_o), .wbEn_o(wbMasterEn_o), .wbResult_o(wbMasterData_o)
    );

    issueLane #(.IsSlave(1'b1)) slaveLane (
        .clk(clk), .rstN_i(rstN_i), .issue_i(issueSlave), .inst_i(inst2_i),
        .rdData1_i(rdData2), .rdData2_i(rdData3), .rdAddr1_o(rdAddr2), .rdAddr2_o(rdAddr3),
        .peerExDest_i(mExDest), .peerExEn_i(mExEn), .peerExResult_i(mExRes),
        .peerWbDest_i(wbMasterReg_o), .peerWbEn_i(wbMasterEn_o), .peerWbResult_i(wbMasterData_o),
        .exDest_o(sExDest), .exEn_o(sExEn), .exResult_o(sExRes),
        .wbDest_o(wbSlaveReg_o), .wbEn_o(wbSlaveEn_o), .wbResult_o(wbSlaveData_o)
    );

    regFile rf (
        .clk(clk), .rstN_i(rstN_i),
        .rdAddr0_i(rdAddr0), .rdAddr1_i(rdAddr1), .rdAddr2_i(rdAddr2), .rdAddr3_i(rdAddr3),
        .rdData0_o(rdData0), .rdData1_o(rdData1), .rdData2_o(rdData2), .rdData3_o(rdData3),
        .wrMasterEn_i(wbMasterEn_o), .wrMasterAddr_i(wbMasterReg_o),
        .wrMasterData_i(wbMasterData_o),
        .wrSlaveEn_i(wbSlaveEn_o), .wrSlaveAddr_i(wbSlaveReg_o), .wrSlaveData_i(wbSlaveData_o)
    );

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
    import isaPkg::*, pipePkg::*;
(
    input  wire          clk,
    input  wire          rstN_i,
    input  wire regAddrT rdAddr0_i,
    input  wire regAddrT rdAddr1_i,
    input  wire regAddrT rdAddr2_i,
    input  wire regAddrT rdAddr3_i,
    output wordT         rdData0_o,
    output wordT         rdData1_o,
    output wordT         rdData2_o,
    output wordT         rdData3_o,
    input  wire          wrMasterEn_i,
    input  wire regAddrT wrMasterAddr_i,
    input  wire wordT    wrMasterData_i,
    input  wire          wrSlaveEn_i,
    input  wire regAddrT wrSlaveAddr_i,
    input  wire wordT    wrSlaveData_i
);

    wordT regs [NumRegs];

    // write-through, slave bypass checked first since it is younger
    function automatic wordT readPort(regAddrT addr);
        if (addr == '0)                                  readPort = '0;
        else if (wrSlaveEn_i && wrSlaveAddr_i == addr)   readPort = wrSlaveData_i;
        else if (wrMasterEn_i && wrMasterAddr_i == addr) readPort = wrMasterData_i;
        else                                             readPort = regs[addr];
    endfunction

    always_comb begin
        rdData0_o = readPort(rdAddr0_i);
        rdData1_o = readPort(rdAddr1_i);
        rdData2_o = readPort(rdAddr2_i);
        rdData3_o = readPort(rdAddr3_i);
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wrMasterEn_i) begin
                regs[wrMasterAddr_i] <= wrMasterData_i;
            end
            if (wrSlaveEn_i) begin
                regs[wrSlaveAddr_i] <= wrSlaveData_i;  // overrides master on same reg
            end
        end
    end

endmodule

`default_nettype wire

//--- pairIssue.sv
`timescale 1ns/1ps
`default_nettype none

module pairIssue
    import isaPkg::*;
(
    input  wire       clk,
    input  wire       rstN_i,
    input  wire instT inst1_i,
    input  wire instT inst2_i,
    input  wire       instValid_i,
    output logic      issueMaster_o,
    output logic      issueSlave_o,
    output logic      fetchStall_o
);

    logic    slavePending;  // master of a dependent pair already went
    logic    writes1, isR2, dependent;
    regAddrT dest1, rs2, rt2;

    always_comb begin
        writes1 = 1'b0;
        dest1   = inst1_i[RtLsb +: RegAddrWidth];
        case (opcodeE'(inst1_i[InstWidth-1:OpcodeLsb]))
            OpSpecial: begin
                dest1 = inst1_i[RdLsb +: RegAddrWidth];
                case (functE'(inst1_i[5:0]))
                    FnSll, FnSrl, FnAddu, FnSubu, FnAnd,
                    FnOr, FnXor, FnNor, FnSlt, FnSltu: writes1 = 1'b1;
                    default:                           writes1 = 1'b0;
                endcase
            end
            OpAddiu, OpSlti, OpAndi, OpOri, OpXori, OpLui: writes1 = 1'b1;
            default: writes1 = 1'b0;
        endcase
    end

    assign rs2  = inst2_i[RsLsb +: RegAddrWidth];
    assign rt2  = inst2_i[RtLsb +: RegAddrWidth];
    assign isR2 = inst2_i[InstWidth-1:OpcodeLsb] == OpSpecial;

    // only one of the pair may go when slave reads what master writes
    assign dependent = writes1 && (dest1 != '0) && ((rs2 == dest1) || (isR2 && rt2 == dest1));

    assign issueMaster_o = instValid_i && !slavePending;
    assign issueSlave_o  = instValid_i && (slavePending || !dependent);
    assign fetchStall_o  = instValid_i && !slavePending && dependent;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            slavePending <= 1'b0;
        end else begin
            slavePending <= fetchStall_o || (slavePending && !instValid_i);
        end
    end

endmodule

`default_nettype wire

//--- issueLane.sv
`timescale 1ns/1ps
`default_nettype none

module issueLane
    import isaPkg::*, pipePkg::*;
#(
    parameter bit IsSlave = 1'b0
) (
    input  wire          clk,
    input  wire          rstN_i,
    input  wire          issue_i,
    input  wire instT    inst_i,
    input  wire wordT    rdData1_i,
    input  wire wordT    rdData2_i,
    output regAddrT      rdAddr1_o,
    output regAddrT      rdAddr2_o,
    input  wire regAddrT peerExDest_i,
    input  wire          peerExEn_i,
    input  wire wordT    peerExResult_i,
    input  wire regAddrT peerWbDest_i,
    input  wire          peerWbEn_i,
    input  wire wordT    peerWbResult_i,
    output regAddrT      exDest_o,
    output logic         exEn_o,
    output wordT         exResult_o,
    output regAddrT      wbDest_o,
    output logic         wbEn_o,
    output wordT         wbResult_o
);

    aluOpE   aluOp, exOp;
    regAddrT rs, rt, dest;
    logic    writeEn, useImm;
    wordT    imm, srcA, srcB;
    fwdSrcE  selA, selB;
    wordT    exA, exB;
    logic [ShamtWidth-1:0] exShamt;

    // stage signals seen as master/slave regardless of which lane this is
    regAddrT mExDest, sExDest, mWbDest, sWbDest;
    logic    mExEn, sExEn, mWbEn, sWbEn;
    wordT    mExRes, sExRes, mWbRes, sWbRes;

    instDecoder decoder (
        .inst_i(inst_i), .aluOp_o(aluOp), .rs_o(rs), .rt_o(rt), .dest_o(dest),
        .writeEn_o(writeEn), .useImm_o(useImm), .imm_o(imm)
    );

    assign rdAddr1_o = rs;
    assign rdAddr2_o = rt;

    assign mExDest = IsSlave ? peerExDest_i   : exDest_o;
    assign mExEn   = IsSlave ? peerExEn_i     : exEn_o;
    assign mExRes  = IsSlave ? peerExResult_i : exResult_o;
    assign mWbDest = IsSlave ? peerWbDest_i   : wbDest_o;
    assign mWbEn   = IsSlave ? peerWbEn_i     : wbEn_o;
    assign mWbRes  = IsSlave ? peerWbResult_i : wbResult_o;
    assign sExDest = IsSlave ? exDest_o   : peerExDest_i;
    assign sExEn   = IsSlave ? exEn_o     : peerExEn_i;
    assign sExRes  = IsSlave ? exResult_o : peerExResult_i;
    assign sWbDest = IsSlave ? wbDest_o   : peerWbDest_i;
    assign sWbEn   = IsSlave ? wbEn_o     : peerWbEn_i;
    assign sWbRes  = IsSlave ? wbResult_o : peerWbResult_i;

    // youngest producer wins: execute before writeback, slave before master
    function automatic fwdSrcE pickSrc(regAddrT addr);
        if (addr == '0)                      pickSrc = FwdReg;
        else if (sExEn && sExDest == addr)   pickSrc = FwdSlaveE;
        else if (mExEn && mExDest == addr)   pickSrc = FwdMasterE;
        else if (sWbEn && sWbDest == addr)   pickSrc = FwdSlaveW;
        else if (mWbEn && mWbDest == addr)   pickSrc = FwdMasterW;
        else                                 pickSrc = FwdReg;
    endfunction

    function automatic wordT fwdData(fwdSrcE sel, wordT regVal);
        case (sel)
            FwdMasterE: fwdData = mExRes;
            FwdSlaveE:  fwdData = sExRes;
            FwdMasterW: fwdData = mWbRes;
            FwdSlaveW:  fwdData = sWbRes;
            default:    fwdData = regVal;
        endcase
    endfunction

    always_comb begin
        selA = pickSrc(rs);
        selB = pickSrc(rt);
        srcA = fwdData(selA, rdData1_i);
        srcB = useImm ? imm : fwdData(selB, rdData2_i);
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            exEn_o <= 1'b0;
            exOp   <= AluNop;
            wbEn_o <= 1'b0;
        end else begin
            exEn_o <= issue_i && writeEn;  // unissued slot is a bubble
            exOp   <= issue_i ? aluOp : AluNop;
            wbEn_o <= exEn_o;
        end
    end

    always_ff @(posedge clk) begin
        exA        <= srcA;
        exB        <= srcB;
        exShamt    <= inst_i[ShamtLsb +: ShamtWidth];
        exDest_o   <= dest;
        wbDest_o   <= exDest_o;
        wbResult_o <= exResult_o;
    end

    aluUnit alu (
        .op_i(exOp), .a_i(exA), .b_i(exB), .shamt_i(exShamt), .result_o(exResult_o)
    );

endmodule

`default_nettype wire

//--- aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit
    import pipePkg::*;
(
    input  wire aluOpE           op_i,
    input  wire wordT            a_i,
    input  wire wordT            b_i,
    input  wire [ShamtWidth-1:0] shamt_i,
    output wordT                 result_o
);

    always_comb begin
        result_o = '0;
        case (op_i)
            AluAdd:  result_o = a_i + b_i;  // no overflow trap
            AluSub:  result_o = a_i - b_i;
            AluAnd:  result_o = a_i & b_i;
            AluOr:   result_o = a_i | b_i;
            AluXor:  result_o = a_i ^ b_i;
            AluNor:  result_o = ~(a_i | b_i);
            AluSlt:  result_o[0] = $signed(a_i) < $signed(b_i);
            AluSltu: result_o[0] = a_i < b_i;
            AluSll:  result_o = b_i << shamt_i;  // shifts act on rt
            AluSrl:  result_o = b_i >> shamt_i;
            AluLui:  result_o = {b_i[WordWidth/2-1:0], {(WordWidth/2){1'b0}}};
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instDecoder
    import isaPkg::*, pipePkg::*;
(
    input  wire instT inst_i,
    output aluOpE     aluOp_o,
    output regAddrT   rs_o,
    output regAddrT   rt_o,
    output regAddrT   dest_o,
    output logic      writeEn_o,
    output logic      useImm_o,
    output wordT      imm_o
);

    opcodeE opcode;
    functE  funct;
    logic   known;
    logic   immSigned;

    assign opcode = opcodeE'(inst_i[InstWidth-1:OpcodeLsb]);
    assign funct  = functE'(inst_i[5:0]);
    assign rs_o   = inst_i[RsLsb +: RegAddrWidth];
    assign rt_o   = inst_i[RtLsb +: RegAddrWidth];

    always_comb begin
        aluOp_o   = AluNop;
        known     = 1'b1;
        useImm_o  = 1'b1;
        immSigned = 1'b0;
        dest_o    = inst_i[RtLsb +: RegAddrWidth];  // I-type writes rt
        case (opcode)
            OpSpecial: begin
                useImm_o = 1'b0;
                dest_o   = inst_i[RdLsb +: RegAddrWidth];
                case (funct)
                    FnSll:   aluOp_o = AluSll;
                    FnSrl:   aluOp_o = AluSrl;
                    FnAddu:  aluOp_o = AluAdd;
                    FnSubu:  aluOp_o = AluSub;
                    FnAnd:   aluOp_o = AluAnd;
                    FnOr:    aluOp_o = AluOr;
                    FnXor:   aluOp_o = AluXor;
                    FnNor:   aluOp_o = AluNor;
                    FnSlt:   aluOp_o = AluSlt;
                    FnSltu:  aluOp_o = AluSltu;
                    default: known = 1'b0;
                endcase
            end
            OpAddiu: begin
                aluOp_o   = AluAdd;
                immSigned = 1'b1;
            end
            OpSlti: begin
                aluOp_o   = AluSlt;
                immSigned = 1'b1;
            end
            OpAndi:  aluOp_o = AluAnd;
            OpOri:   aluOp_o = AluOr;
            OpXori:  aluOp_o = AluXor;
            OpLui:   aluOp_o = AluLui;  // alu moves the low half up
            default: known = 1'b0;
        endcase
    end

    assign imm_o = {{(WordWidth-ImmWidth){immSigned & inst_i[ImmWidth-1]}},
                    inst_i[ImmWidth-1:0]};

    // r0 stays zero, unknown ops become no-ops
    assign writeEn_o = known && (dest_o != '0);

endmodule

`default_nettype wire

//--- pipePkg.sv
`default_nettype none

package pipePkg;

    localparam int WordWidth  = 32;
    localparam int ShamtWidth = 5;

    typedef logic [WordWidth-1:0] wordT;

    typedef enum logic [3:0] {
        AluAdd  = 4'd0,
        AluSub  = 4'd1,
        AluAnd  = 4'd2,
        AluOr   = 4'd3,
        AluXor  = 4'd4,
        AluNor  = 4'd5,
        AluSlt  = 4'd6,
        AluSltu = 4'd7,
        AluSll  = 4'd8,
        AluSrl  = 4'd9,
        AluLui  = 4'd10,
        AluNop  = 4'd11
    } aluOpE;

    // operand source, slave is the younger lane
    typedef enum logic [2:0] {
        FwdReg     = 3'd0,
        FwdMasterE = 3'd1,
        FwdSlaveE  = 3'd2,
        FwdMasterW = 3'd3,
        FwdSlaveW  = 3'd4
    } fwdSrcE;

endpackage

`default_nettype wire

//--- isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int InstWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int NumRegs      = 32;

    // instruction field positions
    localparam int OpcodeLsb = 26;
    localparam int RsLsb     = 21;
    localparam int RtLsb     = 16;
    localparam int RdLsb     = 11;
    localparam int ShamtLsb  = 6;
    localparam int ImmWidth  = 16;

    typedef logic [InstWidth-1:0]    instT;
    typedef logic [RegAddrWidth-1:0] regAddrT;

    typedef enum logic [5:0] {
        OpSpecial = 6'h00,  // R-type, funct selects
        OpAddiu   = 6'h09,
        OpSlti    = 6'h0a,
        OpAndi    = 6'h0c,
        OpOri     = 6'h0d,
        OpXori    = 6'h0e,
        OpLui     = 6'h0f
    } opcodeE;

    typedef enum logic [5:0] {
        FnSll  = 6'h00,
        FnSrl  = 6'h02,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnNor  = 6'h27,
        FnSlt  = 6'h2a,
        FnSltu = 6'h2b
    } functE;

endpackage

`default_nettype wire
